// File: aes_consts.svh
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// Data path widths
`define AES_BLK_W   128   // Block and key width
`define AES_BYTE_W  8
`define AES_WORD_W  32    // One column or key word

// State geometry
`define AES_NBYTES  16
`define AES_NCOLS   4

// Rounds for a 128-bit key
`define AES_NROUNDS 10

// xtime reduction constant, x^8 = x^4 + x^3 + x + 1
`define AES_POLY    8'h1b

// ld sample edge to done edge: 1 + 9*21 + 16 + 1
`define AES_LATENCY 207

`endif

// File: aes_pkg.sv
`default_nettype none

`include "aes_consts.svh"

package aes_pkg;

  typedef logic [`AES_BYTE_W-1:0] byte_t;
  typedef byte_t [0:`AES_WORD_W/`AES_BYTE_W-1] word_t;  // Row 0 in MSBs
  typedef byte_t [0:`AES_NBYTES-1] state_t;             // Column major, byte 0 in MSBs

  typedef logic [$clog2(`AES_NBYTES)-1:0] byte_idx_t;
  typedef logic [$clog2(`AES_NCOLS)-1:0]  col_idx_t;

  // Round sequencer phases
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_SUB,
    PH_MIX,
    PH_UPDATE,
    PH_FINAL
  } phase_e;

  // Controls fanned out from the round FSM
  typedef struct packed {
    logic      sub_en;      // SubBytes slot write
    byte_idx_t sub_idx;
    logic      mix_en;      // MixColumns slot write
    col_idx_t  mix_idx;
    logic      load;        // Initial AddRoundKey
    logic      round_upd;   // State takes mixed state plus key
    logic      final_upd;   // Output takes shifted state plus key
    logic      key_step;    // Next round key
    logic      last_round;
    logic      spare;       // Reserved, always zero
  } round_ctrl_t;

  // Multiply by x in GF(2^8)
  function automatic byte_t xtime(input byte_t b);
    return {b[`AES_BYTE_W-2:0], 1'b0} ^ (`AES_POLY & {`AES_BYTE_W{b[`AES_BYTE_W-1]}});
  endfunction

endpackage

`default_nettype wire

// File: aes_sbox.sv
`default_nettype none

module aes_sbox import aes_pkg::*; (
  input  byte_t a,
  output byte_t d
);

  // Forward substitution table, row n holds entries 16n to 16n+15
  localparam byte_t [0:255] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  assign d = SBOX[a];  // Pure lookup, no state

endmodule

`default_nettype wire

// File: aes_round_ctrl.sv
`default_nettype none

`include "aes_consts.svh"

module aes_round_ctrl import aes_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        ld,
  output round_ctrl_t ctrl,
  output logic        done
);

  phase_e    phase_q;
  byte_idx_t byte_cnt;   // SubBytes slot
  col_idx_t  col_cnt;    // MixColumns slot
  logic [3:0] round_q;   // 1 .. AES_NROUNDS
  logic      load_q;     // Accepted ld, one cycle

  ////////////////////////////////////////////////////////////
  // Phase sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase_q  <= PH_IDLE;
      byte_cnt <= '0;
      col_cnt  <= '0;
      round_q  <= 4'd1;
      load_q   <= 1'b0;
      done     <= 1'b0;
    end else begin
      load_q <= 1'b0;
      done   <= ctrl.final_upd;  // One cycle after the output update
      case (phase_q)
        PH_IDLE: begin
          if (load_q) begin     // Load cycle over, start round 1
            phase_q  <= PH_SUB;
            byte_cnt <= '0;
            round_q  <= 4'd1;
          end else if (ld) begin
            load_q <= 1'b1;
          end
        end
        PH_SUB: begin
          byte_cnt <= byte_cnt + 1'b1;  // Wraps back to 0
          if (byte_cnt == byte_idx_t'(`AES_NBYTES - 1)) begin
            col_cnt <= '0;
            phase_q <= ctrl.last_round ? PH_FINAL : PH_MIX;  // No mix in last round
          end
        end
        PH_MIX: begin
          col_cnt <= col_cnt + 1'b1;
          if (col_cnt == col_idx_t'(`AES_NCOLS - 1))
            phase_q <= PH_UPDATE;
        end
        PH_UPDATE: begin
          round_q  <= round_q + 4'd1;
          byte_cnt <= '0;
          phase_q  <= PH_SUB;
        end
        PH_FINAL: begin
          phase_q <= PH_IDLE;
        end
        default: phase_q <= PH_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl            = '0;
    ctrl.sub_en     = (phase_q == PH_SUB);
    ctrl.sub_idx    = byte_cnt;
    ctrl.mix_en     = (phase_q == PH_MIX);
    ctrl.mix_idx    = col_cnt;
    ctrl.load       = load_q;
    ctrl.round_upd  = (phase_q == PH_UPDATE);
    ctrl.key_step   = (phase_q == PH_UPDATE);  // Next key built during next SubBytes
    ctrl.final_upd  = (phase_q == PH_FINAL);
    ctrl.last_round = (round_q == 4'(`AES_NROUNDS));
    ctrl.spare      = 1'b0;
  end

  // Load, S-box path, mixer and updates never share a cycle
  a_sub_mix_excl: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({ctrl.load, ctrl.sub_en, ctrl.mix_en, ctrl.round_upd, ctrl.final_upd}));

  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    done |=> !done);

endmodule

`default_nettype wire

// File: aes_sub_bytes.sv
`default_nettype none

`include "aes_consts.svh"

module aes_sub_bytes import aes_pkg::*; (
  input  logic        clk,
  input  round_ctrl_t ctrl,
  input  state_t      state_q,
  output state_t      sub_state
);

  byte_t  sb_in;   // Selected state byte
  byte_t  sb_out;
  state_t buf_q;   // Substituted bytes, one slot per state byte

  ////////////////////////////////////////////////////////////
  // Serial S-box, one byte per cycle
  ////////////////////////////////////////////////////////////

  assign sb_in = state_q[ctrl.sub_idx];

  aes_sbox u_sbox (
    .a (sb_in),
    .d (sb_out)
  );

  always_ff @(posedge clk) begin
    if (ctrl.sub_en)
      buf_q[ctrl.sub_idx] <= sb_out;  // Slot matches source byte
  end

  assign sub_state = buf_q;  // Complete after the sixteenth write

  // Slots are filled in order with no gaps
  a_sub_idx_step: assert property (@(posedge clk)
    ctrl.sub_en && (ctrl.sub_idx != byte_idx_t'(`AES_NBYTES - 1)) |=>
      ctrl.sub_en && (ctrl.sub_idx == byte_idx_t'($past(ctrl.sub_idx) + 1'b1)));

endmodule

`default_nettype wire

// File: aes_mix_columns.sv
`default_nettype none

`include "aes_consts.svh"

module aes_mix_columns import aes_pkg::*; (
  input  logic        clk,
  input  round_ctrl_t ctrl,
  input  state_t      sub_state,
  output state_t      sr_state,
  output state_t      mc_state
);

  word_t  col_in;   // Shifted column under mix
  word_t  col_out;
  state_t mc_q;     // Mixed columns, one slot per column

  // Fixed MixColumns matrix rows 2 3 1 1 rotated
  function automatic word_t mix_col(input word_t s);
    word_t m;
    m[0] = xtime(s[0]) ^ xtime(s[1]) ^ s[1] ^ s[2] ^ s[3];
    m[1] = s[0] ^ xtime(s[1]) ^ xtime(s[2]) ^ s[2] ^ s[3];
    m[2] = s[0] ^ s[1] ^ xtime(s[2]) ^ xtime(s[3]) ^ s[3];
    m[3] = xtime(s[0]) ^ s[0] ^ s[1] ^ s[2] ^ xtime(s[3]);
    return m;
  endfunction

  ////////////////////////////////////////////////////////////
  // ShiftRows, wiring only
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < `AES_NCOLS; c++) begin
      for (int r = 0; r < `AES_NCOLS; r++) begin
        // Row r rotated left by r
        sr_state[`AES_NCOLS*c + r] = sub_state[`AES_NCOLS*((c + r) % `AES_NCOLS) + r];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Serial column mixer
  ////////////////////////////////////////////////////////////

  assign col_in  = sr_state[{ctrl.mix_idx, 2'b00} +: `AES_NCOLS];
  assign col_out = mix_col(col_in);

  always_ff @(posedge clk) begin
    if (ctrl.mix_en)
      mc_q[{ctrl.mix_idx, 2'b00} +: `AES_NCOLS] <= col_out;  // Column slot mix_idx
  end

  assign mc_state = mc_q;  // Valid after fourth column

endmodule

`default_nettype wire

// File: aes_key_expand.sv
`default_nettype none

module aes_key_expand import aes_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  round_ctrl_t ctrl,
  input  state_t      key,
  output state_t      round_key
);

  state_t     rk_q;       // Current round key
  logic       busy_q;     // Step in progress
  logic [1:0] step_cnt;   // Byte of SubWord
  byte_t      rcon_q;
  word_t      temp_q;     // SubWord bytes gathered so far
  byte_idx_t  rot_idx;
  byte_t      sb_in;
  byte_t      sb_out;
  word_t      temp_w;     // SubWord(RotWord(w3)) ^ Rcon
  word_t      w0, w1, w2, w3;
  word_t      n0, n1, n2, n3;

  ////////////////////////////////////////////////////////////
  // Serial SubWord of the rotated last word
  ////////////////////////////////////////////////////////////

  assign rot_idx = {2'b11, step_cnt + 2'd1};  // Byte (k+1) mod 4 of w3
  assign sb_in   = rk_q[rot_idx];

  aes_sbox u_sbox (
    .a (sb_in),
    .d (sb_out)
  );

  // Last byte taken straight from the S-box
  assign temp_w = {temp_q[0] ^ rcon_q, temp_q[1], temp_q[2], sb_out};

  assign {w0, w1, w2, w3} = rk_q;
  assign n0 = w0 ^ temp_w;
  assign n1 = w1 ^ n0;
  assign n2 = w2 ^ n1;
  assign n3 = w3 ^ n2;

  ////////////////////////////////////////////////////////////
  // Step control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_q   <= 1'b0;
      step_cnt <= 2'd0;
      rcon_q   <= 8'h01;
    end else if (ctrl.load) begin  // Fresh key, first step right away
      busy_q   <= 1'b1;
      step_cnt <= 2'd0;
      rcon_q   <= 8'h01;
    end else if (ctrl.key_step) begin
      busy_q   <= 1'b1;
      step_cnt <= 2'd0;
    end else if (busy_q) begin
      step_cnt <= step_cnt + 2'd1;
      if (step_cnt == 2'd3) begin
        busy_q <= 1'b0;
        rcon_q <= xtime(rcon_q);  // Next round constant
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy_q)
      temp_q[step_cnt] <= sb_out;
    if (ctrl.load)
      rk_q <= key;
    else if (busy_q && (step_cnt == 2'd3))
      rk_q <= {n0, n1, n2, n3};   // All four words at once
  end

  assign round_key = rk_q;

  // Controller relies on the step being finished by the next update
  a_step_idle: assert property (@(posedge clk) disable iff (!rstn)
    ctrl.key_step |-> !busy_q);

endmodule

`default_nettype wire

// File: aes_cipher_top.sv
`default_nettype none

`include "aes_consts.svh"

module aes_cipher_top import aes_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  input  logic   ld,
  input  state_t key,
  input  state_t text_in,
  output logic   done,
  output state_t text_out
);

  round_ctrl_t ctrl;
  state_t      state_q;     // Cipher state between rounds
  state_t      sub_state;
  state_t      sr_state;
  state_t      mc_state;
  state_t      round_key;
  logic [`AES_BLK_W-1:0] key_q;   // Inputs held from the ld cycle
  logic [`AES_BLK_W-1:0] text_q;

  ////////////////////////////////////////////////////////////
  // Input capture
  ////////////////////////////////////////////////////////////

  // Overwritten by an ignored ld, but no longer read by then
  always_ff @(posedge clk) begin
    if (ld) begin
      key_q  <= key;
      text_q <= text_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // Round blocks
  ////////////////////////////////////////////////////////////

  aes_round_ctrl u_ctrl (
    .clk  (clk),
    .rstn (rstn),
    .ld   (ld),
    .ctrl (ctrl),
    .done (done)
  );

  aes_sub_bytes u_sub (
    .clk       (clk),
    .ctrl      (ctrl),
    .state_q   (state_q),
    .sub_state (sub_state)
  );

  aes_mix_columns u_mix (
    .clk       (clk),
    .ctrl      (ctrl),
    .sub_state (sub_state),
    .sr_state  (sr_state),
    .mc_state  (mc_state)
  );

  aes_key_expand u_key (
    .clk       (clk),
    .rstn      (rstn),
    .ctrl      (ctrl),
    .key       (key_q),
    .round_key (round_key)
  );

  ////////////////////////////////////////////////////////////
  // AddRoundKey and output
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ctrl.load)
      state_q <= text_q ^ key_q;           // Initial whitening
    else if (ctrl.round_upd)
      state_q <= mc_state ^ round_key;     // Rounds 1 to 9
  end

  always_ff @(posedge clk) begin
    if (ctrl.final_upd)
      text_out <= sr_state ^ round_key;    // Round 10 skips MixColumns
  end

  // Fixed latency across FSM and data path
  a_latency: assert property (@(posedge clk) disable iff (!rstn)
    ctrl.load |-> ##(`AES_LATENCY) done);

endmodule

`default_nettype wire

// File: tb_aes_cipher.sv
`default_nettype none

`include "aes_consts.svh"

module tb_aes_cipher import aes_pkg::*;;

  localparam int CLK_HALF  = 50;
  localparam int DRIVE_DLY = 10;   // Inputs change this long after the rising edge
  localparam int NUM_VECS  = 3;
  localparam int NUM_STEPS = 9;
  localparam int WAIT_MAX  = `AES_LATENCY + 20;

  // One known-answer row
  typedef struct packed {
    state_t key;
    state_t pt;
    state_t ct;
  } vector_t;

  // One encryption request
  typedef struct packed {
    int vec;        // Row to encrypt
    int busy_vec;   // Row driven by the ignored ld, -1 for none
    int busy_at;    // Cycles after the ld sample edge
    int gap;        // Idle cycles before ld, -1 for random
  } step_t;

  logic   clk;
  logic   rstn;
  logic   ld;
  state_t key;
  state_t text_in;
  logic   done;
  state_t text_out;

  vector_t     vectors [0:NUM_VECS-1];
  step_t       steps   [0:NUM_STEPS-1];
  logic [31:0] rng_state;
  state_t      last_out;      // Last result expected on text_out
  logic        have_result;
  int          checks;
  int          errors;
  int          timeouts;
  int          s;

  aes_cipher_top u_dut (
    .clk      (clk),
    .rstn     (rstn),
    .ld       (ld),
    .key      (key),
    .text_in  (text_in),
    .done     (done),
    .text_out (text_out)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Compare helpers
  ////////////////////////////////////////////////////////////

  task automatic check_block(input state_t got, input state_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED t=%0t: %s got %0d cycles expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // 32-bit xorshift, shifts 13 17 5
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic set_step(input int idx, input int vec, input int busy_vec,
                          input int busy_at, input int gap);
    steps[idx].vec      = vec;
    steps[idx].busy_vec = busy_vec;
    steps[idx].busy_at  = busy_at;
    steps[idx].gap      = gap;
  endtask

  task automatic load_table();
    // FIPS-197 appendix C.1
    vectors[0].key = 128'h000102030405060708090a0b0c0d0e0f;
    vectors[0].pt  = 128'h00112233445566778899aabbccddeeff;
    vectors[0].ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    // FIPS-197 appendix B
    vectors[1].key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    vectors[1].pt  = 128'h3243f6a8885a308d313198a2e0370734;
    vectors[1].ct  = 128'h3925841d02dc09fbdc118597196a0b32;
    // All zero key and block
    vectors[2].key = '0;
    vectors[2].pt  = '0;
    vectors[2].ct  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    set_step(0, 0, -1, 0, -1);   // Plain runs, random gaps
    set_step(1, 1, -1, 0, -1);
    set_step(2, 2, -1, 0, -1);
    set_step(3, 0, -1, 0, 0);    // Back to back
    set_step(4, 1, -1, 0, 0);
    set_step(5, 2, -1, 0, 0);
    set_step(6, 1, 2, 100, -1);  // ld mid encryption
    set_step(7, 2, 0, 1, 0);     // ld right after the load cycle
    set_step(8, 0, 1, 206, -1);  // ld in the final update cycle
  endtask

  ////////////////////////////////////////////////////////////
  // One encryption with its idle gap
  ////////////////////////////////////////////////////////////

  task automatic run_step(input int idx);
    step_t   st;
    vector_t v;
    int      gap;
    int      n;
    logic    got_done;
    st = steps[idx];
    v  = vectors[st.vec];
    if (st.gap < 0) begin
      rng_state = xorshift32(rng_state);
      gap = int'(rng_state % 8);
    end else begin
      gap = st.gap;
    end

    // Idle gap, previous result must hold
    for (int g = 0; g < gap; g++) begin
      @(posedge clk);
      #DRIVE_DLY;
      check_flag(done, 1'b0, "done in idle gap");
      if (have_result)
        check_block(text_out, last_out, "text_out hold in gap");
    end

    key     = v.key;
    text_in = v.pt;
    ld      = 1'b1;
    @(posedge clk);            // Edge that samples ld
    #DRIVE_DLY;
    ld      = 1'b0;
    key     = ~v.key;          // Inputs only valid in the ld cycle
    text_in = ~v.pt;
    check_flag(done, 1'b0, "done after ld sample");

    n = 0;
    got_done = 1'b0;
    while (!got_done && n < WAIT_MAX) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
      ld = 1'b0;
      if (done) begin
        got_done = 1'b1;
      end else begin
        if (have_result)
          check_block(text_out, last_out, "text_out hold while busy");
        if (st.busy_vec >= 0 && n == st.busy_at) begin
          key     = vectors[st.busy_vec].key;   // Must be ignored
          text_in = vectors[st.busy_vec].pt;
          ld      = 1'b1;
        end
      end
    end

    if (!got_done) begin
      timeouts++;
      $display("ERROR: done never came within %0d cycles in step %0d", WAIT_MAX, idx);
    end else begin
      check_latency(n, `AES_LATENCY, $sformatf("latency step %0d", idx));
      check_block(text_out, v.ct, $sformatf("ciphertext step %0d", idx));
      last_out    = v.ct;
      have_result = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rstn        = 1'b0;
    ld          = 1'b0;
    key         = '0;
    text_in     = '0;
    rng_state   = 32'd24;
    have_result = 1'b0;
    last_out    = '0;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    load_table();

    // Reset for 4 cycles
    repeat (4) begin
      @(posedge clk);
      #DRIVE_DLY;
      check_flag(done, 1'b0, "done during reset");
    end
    rstn = 1'b1;

    s = 0;
    while (s < NUM_STEPS && timeouts == 0) begin
      run_step(s);
      s++;
    end

    // Last done must drop after one cycle
    if (timeouts == 0) begin
      @(posedge clk);
      #DRIVE_DLY;
      check_flag(done, 1'b0, "done pulse width");
    end

    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: aes_cipher_top.f
+incdir+.
aes_pkg.sv
aes_sbox.sv
aes_round_ctrl.sv
aes_sub_bytes.sv
aes_mix_columns.sv
aes_key_expand.sv
aes_cipher_top.sv
tb_aes_cipher.sv
